/* host.sv */
// Host bus subsystem top
`timescale 1ns/1ns

module host
    import hostBusPkg::*;
#(
    parameter int         clockFrequency = 25_000_000,
    parameter int         baudRate       = 3_125_000,
    parameter logic [7:0] ioPort         = 8'h80
) (
    input  logic       clk,
    input  logic       reset,
    input  busCycle_t  bus,
    output busReturn_t busReturn,
    output logic       uartTx
);

    // Which block answers the read issued last clock
    typedef enum logic [1:0] {SOURCE_RAM, SOURCE_UART, SOURCE_UNMAPPED} readSource_t;

    logic        ramSelect;
    logic        memRead;
    logic        memWrite;
    logic        ioRead;
    logic        readValid;
    readSource_t source;
    logic [7:0]  ramData;
    logic [7:0]  uartData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cycle decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign memRead   = bus.memRequest && !bus.ioRequest && bus.read && !bus.write;
    assign memWrite  = bus.memRequest && !bus.ioRequest && bus.write && !bus.read;
    assign ioRead    = bus.ioRequest && !bus.memRequest && bus.read && !bus.write;
    // RAM answers only in block zero
    assign ramSelect = bus.address[15:RAM_ADDRESS_BITS] == RAM_BLOCK;

    ram u_ram (
        .clk        (clk),
        .address    (bus.address[RAM_ADDRESS_BITS-1:0]),
        .writeData  (bus.writeData),
        .writeEnable(memWrite && ramSelect),
        .readEnable (memRead && ramSelect),
        .readData   (ramData)
    );

    uartIo #(
        .clockFrequency(clockFrequency),
        .baudRate      (baudRate),
        .ioPort        (ioPort)
    ) u_uartIo (
        .clk     (clk),
        .reset   (reset),
        .bus     (bus),
        .readData(uartData),
        .uartTx  (uartTx)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read return, one clock after the read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            readValid <= 1'b0;
            source    <= SOURCE_UNMAPPED;
        end else begin
            readValid <= memRead || ioRead;
            if (memRead) begin
                source <= ramSelect ? SOURCE_RAM : SOURCE_UNMAPPED;
            end else if (ioRead) begin
                source <= SOURCE_UART;   // uartIo already floats unused ports
            end
        end
    end

    always_comb begin
        busReturn.readValid = readValid;
        case (source)
            SOURCE_RAM:  busReturn.readData = ramData;
            SOURCE_UART: busReturn.readData = uartData;
            default:     busReturn.readData = UNMAPPED_DATA;
        endcase
    end

    // Master drives one request and one direction at a time
    hostOneRequest: assert property (
        @(posedge clk) disable iff (reset) !(bus.memRequest && bus.ioRequest)
    ) else $error("host: memRequest and ioRequest high together");

    hostOneDirection: assert property (
        @(posedge clk) disable iff (reset) !(bus.read && bus.write)
    ) else $error("host: read and write high together");

endmodule

/* hostBusPkg.sv */
// Host bus types and address map
package hostBusPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus cycle from the master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One cycle per clock with active high strobes
    // Exactly one request and exactly one direction when active
    typedef struct packed {
        logic [15:0] address;
        logic [7:0]  writeData;
        logic        memRequest;
        logic        ioRequest;
        logic        read;
        logic        write;
    } busCycle_t;

    // Read result, valid one clock after the read cycle
    typedef struct packed {
        logic [7:0] readData;
        logic       readValid;
    } busReturn_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 1K of RAM addressed by bits 9..0
    localparam int RAM_ADDRESS_BITS = 10;

    // Block bits 15..10 that select the RAM
    localparam logic [5:0] RAM_BLOCK = 6'h00;

    // Floating bus value for reads nobody answers
    localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

endpackage

/* hostTb.sv */
// Host subsystem testbench
`timescale 1ns/1ns

module hostTb
    import hostBusPkg::*, uartPkg::*;
();

    localparam int         clockFrequency = 25_000_000;
    localparam int         baudRate       = 3_125_000;
    localparam logic [7:0] dataPort       = 8'h80;
    localparam logic [7:0] statusPort     = 8'h81;
    localparam logic [7:0] unusedPort     = 8'h42;
    localparam int         clocksPerBit   = clockFrequency / baudRate;
    // Bus cycles plus 80 clocks per UART byte, doubled for margin
    localparam int         busCycles      = 400;
    localparam int         uartBytes      = 7;
    localparam int         cycleLimit     = 2 * (busCycles + 80 * uartBytes);

    logic                 clk;
    logic                 reset;
    busCycle_t            bus;
    busReturn_t           busReturn;
    logic                 uartTx;

    logic [15:0]          lfsrState = 16'd60718;
    logic [7:0]           modelRam [2**RAM_ADDRESS_BITS];
    logic [7:0]           readExpect [$];
    logic                 readCheck [$];
    logic [7:0]           sentBytes [$];
    logic [DATA_BITS+1:0] rxFrames [$];
    logic                 readAccepted;
    int                   sentTotal = 0;
    int                   receivedCount = 0;
    int                   cycleCount = 0;
    int                   readErrors = 0;
    int                   uartErrors = 0;
    int                   otherErrors = 0;

    host #(
        .clockFrequency(clockFrequency),
        .baudRate      (baudRate),
        .ioPort        (dataPort)
    ) u_host (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .busReturn(busReturn),
        .uartTx   (uartTx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit
    function automatic logic [15:0] randomBits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = {lfsrState[14:0],
                         lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
            value = {value[14:0], lfsrState[0]};
        end
        return value;
    endfunction

    // Expected read byte, RAM only in block zero
    function automatic logic [7:0] expectedRead(input logic [15:0] address);
        if (address[15:RAM_ADDRESS_BITS] == RAM_BLOCK) begin
            return modelRam[address[RAM_ADDRESS_BITS-1:0]];
        end
        return UNMAPPED_DATA;
    endfunction

    // Line levels in send order, start low, LSB first, stop high
    function automatic logic [DATA_BITS+1:0] expectedFrame(input logic [7:0] data);
        logic [DATA_BITS+1:0] frame;
        frame[0] = 1'b0;
        for (int i = 0; i < DATA_BITS; i++) begin
            frame[i+1] = data[i];
        end
        frame[DATA_BITS+1] = 1'b1;
        return frame;
    endfunction

    function automatic busCycle_t makeCycle(input logic isMem, input logic isWrite,
                                            input logic [15:0] address,
                                            input logic [7:0] data);
        busCycle_t cycle;
        cycle            = '0;
        cycle.address    = address;
        cycle.writeData  = data;
        cycle.memRequest = isMem;
        cycle.ioRequest  = !isMem;
        cycle.write      = isWrite;
        cycle.read       = !isWrite;
        return cycle;
    endfunction

    // Next cycle on the next rising edge, so calls run back to back
    task automatic driveCycle(input busCycle_t cycle);
        @(posedge clk);
        bus <= cycle;
    endtask

    task automatic memWrite(input logic [15:0] address, input logic [7:0] data);
        driveCycle(makeCycle(1'b1, 1'b1, address, data));
        if (address[15:RAM_ADDRESS_BITS] == RAM_BLOCK) begin
            modelRam[address[RAM_ADDRESS_BITS-1:0]] = data;
        end
    endtask

    task automatic memRead(input logic [15:0] address);
        readExpect.push_back(expectedRead(address));
        readCheck.push_back(1'b1);
        driveCycle(makeCycle(1'b1, 1'b0, address, 8'h00));
    endtask

    task automatic ioWrite(input logic [7:0] port, input logic [7:0] data);
        driveCycle(makeCycle(1'b0, 1'b1, {port, 8'h00}, data));
    endtask

    task automatic ioRead(input logic [7:0] port, input logic [7:0] expected,
                          input logic check);
        readExpect.push_back(expected);
        readCheck.push_back(check);
        driveCycle(makeCycle(1'b0, 1'b0, {port, 8'h00}, 8'h00));
    endtask

    // Byte into the data port, expected back on the serial line
    task automatic sendByte(input logic [7:0] data);
        ioWrite(dataPort, data);
        sentBytes.push_back(data);
        sentTotal++;
    endtask

    // Status read, data taken once readValid is up
    task automatic readStatus(output logic [7:0] value);
        ioRead(statusPort, 8'h00, 1'b0);
        driveCycle('0);
        @(negedge clk);
        value = busReturn.readData;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read return and serial line checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Read cycle the DUT takes at this edge
    always @(posedge clk) begin
        if (reset) begin
            readAccepted <= 1'b0;
        end else begin
            readAccepted <= bus.read && !bus.write && (bus.memRequest != bus.ioRequest);
        end
    end

    // readValid exactly one clock after each read
    always @(negedge clk) begin
        logic [7:0] expected;
        logic       check;
        if (!reset) begin
            assert (busReturn.readValid == readAccepted) else begin
                $display("FAIL busReturn.readValid: got %h expected %h",
                         busReturn.readValid, readAccepted);
                readErrors++;
            end
            if (readAccepted && readExpect.size() > 0) begin
                expected = readExpect.pop_front();
                check    = readCheck.pop_front();
                if (check) begin
                    assert (busReturn.readData == expected) else begin
                        $display("FAIL busReturn.readData: got %h expected %h",
                                 busReturn.readData, expected);
                        readErrors++;
                    end
                end
            end
        end
    end

    // Start bit edge, then mid-bit samples
    initial begin
        logic [DATA_BITS+1:0] frame;
        forever begin
            @(negedge uartTx);
            if (!reset) begin
                repeat (clocksPerBit / 2) @(negedge clk);
                frame[0] = uartTx;
                for (int i = 1; i < DATA_BITS + 2; i++) begin
                    repeat (clocksPerBit) @(negedge clk);
                    frame[i] = uartTx;
                end
                rxFrames.push_back(frame);
            end
        end
    end

    // Received frames in write order
    always @(negedge clk) begin
        logic [DATA_BITS+1:0] frame;
        logic [7:0]           sentByte;
        if (rxFrames.size() > 0) begin
            frame = rxFrames.pop_front();
            assert (sentBytes.size() > 0) else begin
                $display("Frame on uartTx with no byte written to the data port");
                uartErrors++;
            end
            if (sentBytes.size() > 0) begin
                sentByte = sentBytes.pop_front();
                assert (frame == expectedFrame(sentByte)) else begin
                    $display("FAIL uartTx frame: got %h expected %h",
                             frame, expectedFrame(sentByte));
                    uartErrors++;
                end
            end
            receivedCount++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [15:0] addrList [64];
        logic [15:0] address;
        logic [7:0]  value;
        logic [5:0]  block;
        uartStatus_t status;

        bus   <= '0;
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Idle state after reset
        @(negedge clk);
        assert (busReturn.readValid == 1'b0 && uartTx == 1'b1) else begin
            $display("readValid or uartTx not at idle level after reset");
            otherErrors++;
        end
        ioRead(statusPort, 8'h00, 1'b1);

        // Random RAM writes, then read back
        for (int i = 0; i < 64; i++) begin
            addrList[i] = randomBits(RAM_ADDRESS_BITS);
            memWrite(addrList[i], 8'(randomBits(8)));
        end
        for (int i = 0; i < 64; i++) begin
            memRead(addrList[i]);
        end

        // Nonzero block bits, write dropped and read floats
        for (int i = 0; i < 8; i++) begin
            block   = 6'(randomBits(6)) | 6'h01;
            address = {block, addrList[i][RAM_ADDRESS_BITS-1:0]};
            memWrite(address, 8'(randomBits(8)));
            memRead(addrList[i]);
            memRead(address);
        end

        // One byte into an idle UART
        sendByte(8'(randomBits(8)));
        readStatus(value);
        assert (value[1:0] != 2'b00) else begin
            $display("Status after a data write shows neither txBusy nor holdFull");
            otherErrors++;
        end
        while (receivedCount < 1) @(posedge clk);

        // Polled sends
        for (int i = 0; i < 5; i++) begin
            do begin
                readStatus(value);
                status = uartStatus_t'(value);
            end while (status.holdFull);
            sendByte(8'(randomBits(8)));
        end

        // Data port and unused port
        ioRead(dataPort, UNMAPPED_DATA, 1'b1);
        ioRead(unusedPort, UNMAPPED_DATA, 1'b1);
        driveCycle('0);

        while (receivedCount < sentTotal) @(posedge clk);
        // Holding register is empty here, so a misdecoded write would send a frame
        ioWrite(unusedPort, 8'h5A);
        driveCycle('0);
        // Room for a stray frame to show up
        repeat (12 * clocksPerBit) @(posedge clk);

        $display("Errors: read %0d, uart %0d, other %0d", readErrors, uartErrors, otherErrors);
        if (readErrors + uartErrors + otherErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run did not finish within %0d cycles", cycleLimit);
        $display("Errors: read %0d, uart %0d, other %0d", readErrors, uartErrors, otherErrors);
        $display("Verification failed");
        $finish;
    end

endmodule

/* ram.sv */
// Single-port 1K RAM
`timescale 1ns/1ns

module ram
    import hostBusPkg::*;
(
    input  logic                        clk,
    input  logic [RAM_ADDRESS_BITS-1:0] address,
    input  logic [7:0]                  writeData,
    input  logic                        writeEnable,
    input  logic                        readEnable,
    output logic [7:0]                  readData
);

    // Storage array, 2**RAM_ADDRESS_BITS bytes
    logic [7:0] memory [2**RAM_ADDRESS_BITS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port and registered read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        // Store on the write strobe
        if (writeEnable) begin
            memory[address] <= writeData;
        end
        // Output register holds its byte between reads
        if (readEnable) begin
            readData <= memory[address];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Host decode must never read and write in one cycle
    ramOneStrobe: assert property (
        @(posedge clk) !(writeEnable && readEnable)
    ) else $error("ram: writeEnable and readEnable high together");

endmodule

/* run.sh */
#!/bin/sh
# Build and run the host subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns --top-module hostTb -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VhostTb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi

/* sources.f */
hostBusPkg.sv
uartPkg.sv
ram.sv
uartCore.sv
uartIo.sv
host.sv
hostTb.sv

/* uartCore.sv */
// UART transmit serializer
`timescale 1ns/1ns

module uartCore
    import uartPkg::*;
#(
    parameter int clockFrequency = 25_000_000,
    parameter int baudRate       = 3_125_000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic [DATA_BITS-1:0] data,
    output logic                 busy,
    output logic                 uartTx
);

    // Clocks per bit period and frame length
    localparam int clocksPerBit = clockFrequency / baudRate;
    localparam int frameBits    = DATA_BITS + 2;
    localparam int baudWidth    = (clocksPerBit > 1) ? $clog2(clocksPerBit) : 1;
    localparam int bitWidth     = $clog2(frameBits);

    // Shift register, LSB is the line level
    logic [frameBits-1:0] shifter;
    // Clocks into the current bit
    logic [baudWidth-1:0] baudCount;
    // Bits left after the current one
    logic [bitWidth-1:0]  bitCount;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            shifter   <= '1;
            baudCount <= '0;
            bitCount  <= '0;
        end else if (start && !busy) begin
            // Stop bit, data LSB first, start bit at the line end
            busy      <= 1'b1;
            shifter   <= {1'b1, data, 1'b0};
            baudCount <= '0;
            bitCount  <= bitWidth'(frameBits - 1);
        end else if (busy) begin
            if (baudCount == baudWidth'(clocksPerBit - 1)) begin
                // End of a bit period, move to the next bit
                baudCount <= '0;
                shifter   <= {1'b1, shifter[frameBits-1:1]};
                if (bitCount == '0) begin
                    busy <= 1'b0;   // stop bit done
                end else begin
                    bitCount <= bitCount - 1'b1;
                end
            end else begin
                baudCount <= baudCount + 1'b1;
            end
        end
    end

    // Ones shift in behind the frame so the line idles high
    assign uartTx = shifter[0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Port logic must wait for the frame to finish
    coreStartIdle: assert property (
        @(posedge clk) disable iff (reset) start |-> !busy
    ) else $error("uartCore: start while busy");

    // Idle line is the mark level
    coreIdleHigh: assert property (
        @(posedge clk) disable iff (reset) !busy |-> uartTx
    ) else $error("uartCore: uartTx low while idle");

endmodule

/* uartIo.sv */
// UART I/O port block
`timescale 1ns/1ns

module uartIo
    import hostBusPkg::*, uartPkg::*;
#(
    parameter int         clockFrequency = 25_000_000,
    parameter int         baudRate       = 3_125_000,
    parameter logic [7:0] ioPort         = 8'h80
) (
    input  logic       clk,
    input  logic       reset,
    input  busCycle_t  bus,
    output logic [7:0] readData,
    output logic       uartTx
);

    // Status port sits right above the data port
    localparam logic [7:0] statusPort = ioPort + 8'd1;

    logic                 ioCycle;
    logic                 dataWrite;
    logic                 ioRead;
    logic [DATA_BITS-1:0] holdData;
    logic                 holdFull;
    logic                 start;
    logic                 txBusy;
    uartStatus_t          status;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port decode on the upper address byte
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ioCycle   = bus.ioRequest && !bus.memRequest;
    assign dataWrite = ioCycle && bus.write && !bus.read && bus.address[15:8] == ioPort;
    assign ioRead    = ioCycle && bus.read && !bus.write;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Holding register and feed into the serializer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Hand the byte over as soon as the core is idle
    assign start = holdFull && !txBusy;

    always_ff @(posedge clk) begin
        if (reset) begin
            holdFull <= 1'b0;
        end else if (start) begin
            holdFull <= 1'b0;
        end else if (dataWrite) begin
            holdFull <= 1'b1;
        end
    end

    // Writes into a full holding register are lost
    always_ff @(posedge clk) begin
        if (dataWrite && !holdFull) begin
            holdData <= bus.writeData;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data, status port or floating bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign status = '{reserved: '0, holdFull: holdFull, txBusy: txBusy};

    always_ff @(posedge clk) begin
        if (ioRead) begin
            readData <= (bus.address[15:8] == statusPort) ? status : UNMAPPED_DATA;
        end
    end

    uartCore #(
        .clockFrequency(clockFrequency),
        .baudRate      (baudRate)
    ) u_uartCore (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .data  (holdData),
        .busy  (txBusy),
        .uartTx(uartTx)
    );

endmodule

/* uartPkg.sv */
// UART frame and status layout
package uartPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Data bits per frame, sent LSB first
    // Frame adds one start bit and one stop bit around them
    localparam int DATA_BITS = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Status port byte
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bit 1 set while a byte waits in the holding register
    // Bit 0 set while the serializer shifts a frame out
    typedef struct packed {
        logic [5:0] reserved;
        logic       holdFull;
        logic       txBusy;
    } uartStatus_t;

endpackage
